/* logic/ksz_macros.svh */
`ifndef KSZ_MACROS_SVH
`define KSZ_MACROS_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define KSZ_DATA_W        16     // multiplexed address/data bus
`define KSZ_OFFSET_W      8      // chip register offset
`define KSZ_REG_ADDR_W    16     // register-port write address

// register-port address of the chip-access register
`define KSZ_REG_PORT_ADDR 16'h000C

// ----------------------------------------
// power-up timing, in sysclk cycles
// ----------------------------------------
`define KSZ_RESET_CYCLES  20     // stands in for 10 ms of chip reset
`define KSZ_WARMUP_CYCLES 40     // stands in for 50 ms of warm-up
`define KSZ_TIMER_W       8      // wide enough for both intervals

`endif

/* logic/kszBusPkg.sv */
package kszBusPkg;

    // sequencer states, one access at a time on the chip bus
    typedef enum logic [3:0] {
        idle         = 4'd0,
        resetAssert  = 4'd1,   // chip reset held low
        resetWait    = 4'd2,   // warm-up after reset release
        addrStart    = 4'd3,
        addrHold     = 4'd4,
        addrEnd      = 4'd5,
        readStart    = 4'd6,
        readDmaStart = 4'd7,   // dma read, strobe already low
        readHold     = 4'd8,
        readEnd      = 4'd9,
        writeStart   = 4'd10,
        writeHold    = 4'd11,
        writeEnd     = 4'd12
    } busStateT;

    // byte enables, sd[15:12] during the address phase
    // the chip splits its space into 32-bit chunks, one bit per byte lane
    typedef logic [3:0] byteEnT;

    localparam byteEnT beWordLo = 4'b0011;   // word at offset 0 of the chunk
    localparam byteEnT beWordHi = 4'b1100;   // word at offset 2 of the chunk

endpackage

/* logic/kszHostPkg.sv */
package kszHostPkg;

`include "ksz_macros.svh"

    // 32-bit word written through the register port
    typedef struct packed {
        logic [3:0]               zero;       // reserved, written as 0
        logic                     dma;
        logic                     chipReset;  // restart the power-up sequence
        logic                     isWrite;    // 0 read, 1 write
        logic                     isWord;     // 0 byte, 1 word
        logic [`KSZ_OFFSET_W-1:0] addr;
        logic [`KSZ_DATA_W-1:0]   data;
    } regCmdWordT;

    // one chip access as the sequencer sees it, 27 bits
    typedef struct packed {
        logic                     isDma;
        logic                     isWrite;
        logic                     isWord;
        logic [`KSZ_OFFSET_W-1:0] addr;       // ignored for dma
        logic [`KSZ_DATA_W-1:0]   data;       // ignored for reads
    } cmdFieldsT;

endpackage

/* logic/byteLaneAddr.sv */
`timescale 1ns/1ps
`include "ksz_macros.svh"

module byteLaneAddr (
    input  logic [`KSZ_OFFSET_W-1:0] offset,   // register offset 0x00-0xff
    input  logic                     isWord,   // 0 byte, 1 word
    output logic [`KSZ_DATA_W-1:0]   addr      // address as the chip wants it on sd
);
    import kszBusPkg::*;

    byteEnT byteEn;

    // lane select from the low offset bits
    // odd word offsets get no lane at all, not supported by the chip setup
    always_comb begin
        byteEn = '0;
        case (offset[1:0])
            2'd0:    byteEn = isWord ? beWordLo : 4'b0001;
            2'd1:    byteEn = isWord ? 4'b0000 : 4'b0010;
            2'd2:    byteEn = isWord ? beWordHi : 4'b0100;
            default: byteEn = isWord ? 4'b0000 : 4'b1000;
        endcase
    end

    // be in the top nibble, 11:8 unused
    assign addr = {byteEn, 4'h0, offset};

endmodule

/* logic/powerUpTimer.sv */
`timescale 1ns/1ps
`include "ksz_macros.svh"

module powerUpTimer (
    input  logic sysclk,
    input  logic reset,
    input  logic start,      // restart from the reset interval
    output logic rstDone,    // pulse, chip reset may be released
    output logic warmDone    // pulse, chip is ready for io
);
    logic [`KSZ_TIMER_W-1:0] count;
    logic                    inReset;   // counting the reset interval
    logic                    inWarm;    // counting the warm-up interval

    // self-starts out of reset, so the chip comes up without a start pulse
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            count    <= '0;
            inReset  <= 1'b1;
            inWarm   <= 1'b0;
            rstDone  <= 1'b0;
            warmDone <= 1'b0;
        end else begin
            rstDone  <= 1'b0;
            warmDone <= 1'b0;
            if (start) begin
                count   <= '0;
                inReset <= 1'b1;
                inWarm  <= 1'b0;
            end else if (inReset) begin
                if (count == `KSZ_TIMER_W'(`KSZ_RESET_CYCLES - 1)) begin
                    count   <= '0;
                    inReset <= 1'b0;
                    inWarm  <= 1'b1;
                    rstDone <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end else if (inWarm) begin
                if (count == `KSZ_TIMER_W'(`KSZ_WARMUP_CYCLES - 1)) begin
                    inWarm   <= 1'b0;          // hold here until the next start
                    warmDone <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    doneExclusive: assert property (@(posedge sysclk) disable iff (!reset)
        !(rstDone && warmDone));

endmodule

/* logic/regCmdDecode.sv */
`timescale 1ns/1ps
`include "ksz_macros.svh"

module regCmdDecode (
    input  logic                       sysclk,
    input  logic                       reset,
    input  logic                       regWen,        // single-cycle register write
    input  logic [`KSZ_REG_ADDR_W-1:0] regWaddr,
    input  kszHostPkg::regCmdWordT     regWdata,
    output logic                       regCmdValid,   // access request, one cycle
    output logic                       regResetReq,   // chip reset request, one cycle
    output kszHostPkg::cmdFieldsT      regFields
);
    logic hit;

    // only the chip-access register is ours
    assign hit = regWen && (regWaddr == `KSZ_REG_PORT_ADDR);

    // ----------------------------------------
    // request strobes
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            regCmdValid <= 1'b0;
            regResetReq <= 1'b0;
        end else begin
            regResetReq <= hit && regWdata.chipReset;    // reset wins over the access bits
            regCmdValid <= hit && !regWdata.chipReset;
        end
    end

    // ----------------------------------------
    // unpack the word, payload only
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (hit) begin
            regFields.isDma   <= regWdata.dma;
            regFields.isWrite <= regWdata.isWrite;
            regFields.isWord  <= regWdata.isWord;
            regFields.addr    <= regWdata.addr;
            regFields.data    <= regWdata.data;
        end
    end

    // a reset word never also starts an access
    reqExclusive: assert property (@(posedge sysclk) disable iff (!reset)
        !(regCmdValid && regResetReq));

endmodule

/* logic/kszBusCtrl.sv */
`timescale 1ns/1ps
`include "ksz_macros.svh"

module kszBusCtrl (
    input  logic                     sysclk,
    input  logic                     reset,
    // host command port, four-phase req/ack
    input  logic                     cmdReq,
    output logic                     cmdAck,
    input  logic                     isDma,
    input  logic                     isWrite,
    input  logic                     isWord,
    input  logic [`KSZ_OFFSET_W-1:0] regAddr,
    input  logic [`KSZ_DATA_W-1:0]   dataIn,
    output logic [`KSZ_DATA_W-1:0]   dataOut,
    output logic                     dataValid,
    // init handshake with the higher layer
    output logic                     initReq,
    input  logic                     initAck,
    // decoded register port
    input  logic                     regCmdValid,
    input  logic                     regResetReq,
    input  kszHostPkg::cmdFieldsT    regFields,
    output logic                     busError,    // register access while busy
    output logic                     busIdle,
    // power-up timer
    output logic                     timerStart,
    input  logic                     rstDone,
    input  logic                     warmDone,
    // chip bus
    output logic                     ethRstn,
    output logic                     ethCmd,      // 1 address, 0 data
    output logic                     ethRdn,
    output logic                     ethWrn,
    output logic [`KSZ_DATA_W-1:0]   sdOut,
    input  logic [`KSZ_DATA_W-1:0]   sdIn
);
    import kszBusPkg::*;
    import kszHostPkg::*;

    busStateT                 state;
    logic                     subPhase;    // second pass through addrEnd / readStart
    logic                     fromHost;    // current access came from the host port
    cmdFieldsT                cmd;         // latched access
    cmdFieldsT                hostFields;
    cmdFieldsT                startCmd;
    logic [`KSZ_DATA_W-1:0]   hostAddr;
    logic [`KSZ_DATA_W-1:0]   regPortAddr;
    logic [`KSZ_DATA_W-1:0]   startAddr;
    logic                     hostGo;
    logic                     regGo;

    byteLaneAddr hostLane_i (.offset(regAddr), .isWord(isWord), .addr(hostAddr));
    byteLaneAddr regLane_i (.offset(regFields.addr), .isWord(regFields.isWord),
                            .addr(regPortAddr));

    // ----------------------------------------
    // arbitration, register port first
    // ----------------------------------------
    assign hostFields = '{isDma: isDma, isWrite: isWrite, isWord: isWord,
                          addr: regAddr, data: dataIn};
    assign regGo      = (state == idle) && regCmdValid;
    assign hostGo     = (state == idle) && cmdReq && !cmdAck && !regCmdValid;  // needs a fresh req
    assign startCmd   = regGo ? regFields : hostFields;
    assign startAddr  = regGo ? regPortAddr : hostAddr;
    assign busIdle    = (state == idle);

    // ----------------------------------------
    // control fsm
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            state      <= resetAssert;
            subPhase   <= 1'b0;
            fromHost   <= 1'b0;
            ethRstn    <= 1'b0;
            ethCmd     <= 1'b0;
            ethRdn     <= 1'b1;
            ethWrn     <= 1'b1;
            cmdAck     <= 1'b0;
            dataValid  <= 1'b0;
            initReq    <= 1'b0;
            busError   <= 1'b0;
            timerStart <= 1'b0;
        end else begin
            timerStart <= 1'b0;
            // ack drops once the host let go and the access is done
            if (cmdAck && !cmdReq && state == idle) begin
                cmdAck    <= 1'b0;
                dataValid <= 1'b0;
            end
            if (initAck) initReq <= 1'b0;
            if (regCmdValid) busError <= (state != idle);    // set if busy, clear if taken
            if (regResetReq) begin
                state      <= resetAssert;
                timerStart <= 1'b1;
                ethRstn    <= 1'b0;
                ethCmd     <= 1'b0;
                ethRdn     <= 1'b1;
                ethWrn     <= 1'b1;
                cmdAck     <= 1'b0;
                dataValid  <= 1'b0;
                initReq    <= 1'b0;
                busError   <= 1'b0;
            end else begin
                case (state)
                    idle: if (hostGo || regGo) begin
                        fromHost <= hostGo;
                        subPhase <= 1'b0;
                        if (hostGo) cmdAck <= 1'b1;
                        ethCmd   <= !startCmd.isDma;            // dma has no address phase
                        if (startCmd.isDma && startCmd.isWrite) state <= writeStart;
                        else if (startCmd.isDma) begin
                            state  <= readDmaStart;
                            ethRdn <= 1'b0;
                        end else state <= addrStart;
                    end
                    resetAssert: if (rstDone) begin
                        ethRstn <= 1'b1;
                        state   <= resetWait;
                    end
                    resetWait: if (warmDone) begin
                        initReq <= 1'b1;                        // higher layer sets the chip up
                        state   <= idle;
                    end
                    addrStart: begin
                        ethWrn   <= 1'b0;
                        subPhase <= 1'b0;
                        state    <= addrHold;
                    end
                    addrHold:  state <= addrEnd;
                    addrEnd: if (!subPhase) begin
                        ethWrn   <= 1'b1;                       // one cycle high before data
                        subPhase <= 1'b1;
                    end else begin
                        ethCmd   <= 1'b0;
                        subPhase <= 1'b0;
                        state    <= cmd.isWrite ? writeStart : readStart;
                    end
                    writeStart: begin
                        ethWrn <= 1'b0;
                        state  <= writeHold;
                    end
                    writeHold: state <= writeEnd;
                    writeEnd: begin
                        ethWrn <= 1'b1;
                        state  <= idle;
                    end
                    readStart: if (!subPhase) begin
                        ethRdn   <= 1'b0;
                        subPhase <= 1'b1;
                    end else state <= readHold;
                    readDmaStart: state <= readHold;
                    readHold:     state <= readEnd;
                    readEnd: begin                              // third low cycle, data sampled
                        if (fromHost) dataValid <= 1'b1;
                        ethRdn <= 1'b1;
                        state  <= idle;
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // ----------------------------------------
    // payload, latched command and bus data
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (state == idle && (hostGo || regGo)) begin
            cmd   <= startCmd;
            sdOut <= startCmd.isDma ? startCmd.data : startAddr;
        end else if (state == addrEnd && subPhase && cmd.isWrite) begin
            sdOut <= cmd.data;
        end
        if (state == readEnd) dataOut <= sdIn;
    end

    strobeExclusive: assert property (@(posedge sysclk) disable iff (!reset)
        !(!ethRdn && !ethWrn));
    writeStrobeLen: assert property (@(posedge sysclk) disable iff (!reset || regResetReq)
        $fell(ethWrn) |=> !ethWrn ##1 ethWrn);
    ackAfterReq: assert property (@(posedge sysclk) disable iff (!reset)
        $fell(cmdAck) && !$past(regResetReq) |-> !$past(cmdReq));

endmodule

/* logic/kszBusTop.sv */
`timescale 1ns/1ps
`include "ksz_macros.svh"

module kszBusTop (
    input  logic                       sysclk,
    input  logic                       reset,
    // host command port
    input  logic                       cmdReq,
    output logic                       cmdAck,
    input  logic                       isDma,
    input  logic                       isWrite,
    input  logic                       isWord,
    input  logic [`KSZ_OFFSET_W-1:0]   regAddr,
    input  logic [`KSZ_DATA_W-1:0]     dataIn,
    output logic [`KSZ_DATA_W-1:0]     dataOut,
    output logic                       dataValid,
    output logic                       initReq,
    input  logic                       initAck,
    // register port
    input  logic                       regWen,
    input  logic [`KSZ_REG_ADDR_W-1:0] regWaddr,
    input  kszHostPkg::regCmdWordT     regWdata,
    output logic                       busError,
    output logic                       busIdle,
    // chip bus
    output logic                       ethRstn,
    output logic                       ethCmd,
    output logic                       ethRdn,
    output logic                       ethWrn,
    inout  wire  [`KSZ_DATA_W-1:0]     sd
);
    import kszHostPkg::*;

    logic                   regCmdValid;
    logic                   regResetReq;
    cmdFieldsT              regFields;
    logic                   timerStart;
    logic                   rstDone;
    logic                   warmDone;
    logic [`KSZ_DATA_W-1:0] sdOut;

    // drive the bus except while the chip is reading out
    assign sd = ethRdn ? sdOut : 'z;

    regCmdDecode decode_i (.sysclk, .reset, .regWen, .regWaddr, .regWdata,
                           .regCmdValid, .regResetReq, .regFields);

    powerUpTimer timer_i (.sysclk, .reset, .start(timerStart), .rstDone, .warmDone);

    kszBusCtrl ctrl_i (
        .sysclk, .reset,
        .cmdReq, .cmdAck, .isDma, .isWrite, .isWord, .regAddr, .dataIn,
        .dataOut, .dataValid, .initReq, .initAck,
        .regCmdValid, .regResetReq, .regFields, .busError, .busIdle,
        .timerStart, .rstDone, .warmDone,
        .ethRstn, .ethCmd, .ethRdn, .ethWrn, .sdOut, .sdIn(sd)
    );

endmodule

/* bench/clkGen.sv */
`timescale 1ns/1ps

module clkGen #(
    parameter int periodNs    = 4,
    parameter int resetCycles = 2
) (
    output logic sysclk,
    output logic reset     // active low
);
    initial begin
        sysclk = 1'b0;
        forever #(periodNs / 2.0) sysclk = ~sysclk;
    end

    // held low for a couple of edges, released on a rising edge
    initial begin
        reset = 1'b0;
        repeat (resetCycles) @(posedge sysclk);
        reset <= 1'b1;
    end

endmodule

/* bench/kszChipModel.sv */
`timescale 1ns/1ps
`include "ksz_macros.svh"

module kszChipModel (
    input  logic                   ethRstn,
    input  logic                   ethCmd,
    input  logic                   ethRdn,
    input  logic                   ethWrn,
    inout  wire  [`KSZ_DATA_W-1:0] sd
);
    logic [`KSZ_DATA_W-1:0] regs [128];     // 16-bit words, offset bits 7:1
    logic [`KSZ_DATA_W-1:0] dmaQueue [$];
    logic [`KSZ_DATA_W-1:0] latchedAddr;    // be in 15:12, offset in 7:0
    logic [`KSZ_DATA_W-1:0] readWord;
    logic                   addrPending;    // address phase seen, data phase due

    initial begin
        foreach (regs[i]) regs[i] = '0;
        addrPending = 1'b0;
        readWord    = '0;
    end

    // chip only drives while the read strobe is low
    assign sd = ethRdn ? 'z : readWord;

    always @(negedge ethRstn) addrPending = 1'b0;

    // ----------------------------------------
    // write strobe, latched on its rising edge
    // ----------------------------------------
    always @(posedge ethWrn) begin
        if (ethRstn === 1'b1) begin
            if (ethCmd) begin
                latchedAddr = sd;
                addrPending = 1'b1;
            end else if (addrPending) begin
                if (latchedAddr[12] || latchedAddr[14]) regs[latchedAddr[7:1]][7:0] = sd[7:0];
                if (latchedAddr[13] || latchedAddr[15]) regs[latchedAddr[7:1]][15:8] = sd[15:8];
                addrPending = 1'b0;
            end else begin
                dmaQueue.push_back(sd);        // no address phase, so dma
            end
        end
    end

    // read data is fixed for the whole strobe
    always @(negedge ethRdn) begin
        if (addrPending) readWord = regs[latchedAddr[7:1]];
        else if (dmaQueue.size() > 0) readWord = dmaQueue[0];
        else readWord = 16'hdead;              // dma queue ran dry
    end

    always @(posedge ethRdn) begin
        if (ethRstn === 1'b1) begin
            if (addrPending) addrPending = 1'b0;
            else if (dmaQueue.size() > 0) void'(dmaQueue.pop_front());
        end
    end

endmodule

/* bench/kszBusTb.sv */
`timescale 1ns/1ps
`include "ksz_macros.svh"

module kszBusTb;
    import kszHostPkg::*;

    localparam int timeoutCycles = 4000;       // well above the whole sequence

    logic                          sysclk;
    logic                          reset;
    logic                          cmdReq, cmdAck, isDma, isWrite, isWord;
    logic [`KSZ_OFFSET_W-1:0]      regAddr;
    logic [`KSZ_DATA_W-1:0]        dataIn, dataOut;
    logic                          dataValid, initReq, initAck;
    logic                          regWen;
    logic [`KSZ_REG_ADDR_W-1:0]    regWaddr;
    regCmdWordT                    regWdata;
    logic                          busError, busIdle;
    logic                          ethRstn, ethCmd, ethRdn, ethWrn;
    wire  [`KSZ_DATA_W-1:0]        sd;

    logic [15:0] expAddr = '0;                 // address phase value of the current access
    logic [15:0] expData = '0;                 // dataOut due at dataValid
    logic        dmaActive = 1'b0;
    logic        readActive = 1'b0;            // host read in flight
    logic        pokeBusy = 1'b0;              // register write sent while busy
    logic [7:0]  mirror [logic [7:0]];         // expected chip bytes by offset
    logic [15:0] dmaExp [$];
    logic [31:0] lfsr = 32'h66b39725;
    int          cycles = 0;
    int          lowCycles = 0;                // cycles with ethRstn low
    int          highCycles = 0;               // cycles since ethRstn rose

    clkGen #(.periodNs(4), .resetCycles(2)) clk_i (.sysclk, .reset);

    kszBusTop dut_i (.sysclk, .reset, .cmdReq, .cmdAck, .isDma, .isWrite, .isWord,
                     .regAddr, .dataIn, .dataOut, .dataValid, .initReq, .initAck,
                     .regWen, .regWaddr, .regWdata, .busError, .busIdle,
                     .ethRstn, .ethCmd, .ethRdn, .ethWrn, .sd);

    kszChipModel chip_i (.ethRstn, .ethCmd, .ethRdn, .ethWrn, .sd);

    // ----------------------------------------
    // error reporting
    // ----------------------------------------
    task automatic abortRun();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic valueMismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        abortRun();
    endtask

    task automatic checkFailed(input string msg);
        $display("error at %0t: %s", $time, msg);
        abortRun();
    endtask

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) checkFailed("timeout, the sequence did not finish");
    end

    always @(posedge sysclk) begin
        lowCycles  <= ethRstn ? 0 : lowCycles + 1;
        highCycles <= ethRstn ? highCycles + 1 : 0;
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    rstLen: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(ethRstn) |-> lowCycles >= `KSZ_RESET_CYCLES)
        else valueMismatch("ethRstn low cycles", $sampled(lowCycles), `KSZ_RESET_CYCLES);
    warmLen: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(initReq) |-> highCycles >= `KSZ_WARMUP_CYCLES)
        else valueMismatch("warm-up cycles", $sampled(highCycles), `KSZ_WARMUP_CYCLES);
    resetQuiet: assert property (@(posedge sysclk) disable iff (!reset)
        !ethRstn |-> ethRdn && ethWrn && !initReq && !cmdAck && !dataValid && !busError)
        else checkFailed("strobe or handshake active while the chip is in reset");
    initDrop: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(initAck) |=> !initReq)
        else checkFailed("initReq stayed high after initAck");
    addrOnBus: assert property (@(posedge sysclk) disable iff (!reset)
        ethCmd && !ethWrn |-> sd == expAddr)
        else valueMismatch("sd", $sampled(sd), $sampled(expAddr));
    readData: assert property (@(posedge sysclk) disable iff (!reset)
        dataValid |-> dataOut == expData)
        else valueMismatch("dataOut", $sampled(dataOut), $sampled(expData));
    ackNeedsReq: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(cmdAck) |-> $past(cmdReq))
        else checkFailed("cmdAck rose without cmdReq");
    ackHolds: assert property (@(posedge sysclk) disable iff (!reset)
        cmdAck && cmdReq |=> cmdAck)
        else checkFailed("cmdAck fell while cmdReq was high");
    validInAck: assert property (@(posedge sysclk) disable iff (!reset)
        dataValid |-> cmdAck && readActive)
        else checkFailed("dataValid high outside a host read");
    validSeen: assert property (@(posedge sysclk) disable iff (!reset)
        readActive && $fell(cmdAck) |-> $past(dataValid))
        else checkFailed("host read finished without dataValid");
    busyOnBus: assert property (@(posedge sysclk) disable iff (!reset)
        ethCmd || !ethWrn || !ethRdn |-> !busIdle)
        else checkFailed("busIdle high while a bus phase is active");
    dmaNoAddr: assert property (@(posedge sysclk) disable iff (!reset)
        dmaActive |-> !ethCmd)
        else checkFailed("ethCmd high during a dma access");
    errOnPoke: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(busError) |-> pokeBusy)
        else checkFailed("busError rose with no register write while busy");
    wrStrobe: assert property (@(posedge sysclk) disable iff (!reset)
        $fell(ethWrn) |=> !ethWrn ##1 ethWrn)
        else checkFailed("write strobe not exactly 2 cycles");
    strobesApart: assert property (@(posedge sysclk) disable iff (!reset)
        !(!ethRdn && !ethWrn))
        else checkFailed("ethRdn and ethWrn low together");
    noContention: assert property (@(posedge sysclk) disable iff (!reset)
        !ethRdn |-> !$isunknown(sd))
        else checkFailed("sd unknown during a read, DUT and chip both drive it");

    // ----------------------------------------
    // expected values
    // ----------------------------------------
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return r;
    endfunction

    // one enable per byte lane of the 32-bit chunk
    function automatic logic [15:0] laneAddr(input logic [7:0] off, input logic word);
        logic [3:0] lanes;
        if (word) lanes = off[1] ? 4'b1100 : 4'b0011;
        else lanes = 4'b0001 << off[1:0];
        return {lanes, 4'h0, off};
    endfunction

    function automatic logic [7:0] byteAt(input logic [7:0] off);
        return mirror.exists(off) ? mirror[off] : 8'h00;
    endfunction

    function automatic void storeMirror(input logic [7:0] off, input logic word,
                                        input logic [15:0] data);
        if (word) begin
            mirror[off]        = data[7:0];
            mirror[off + 8'd1] = data[15:8];
        end else if (off[0]) begin
            mirror[off] = data[15:8];          // odd bytes ride the upper lane
        end else begin
            mirror[off] = data[7:0];
        end
    endfunction

    // ----------------------------------------
    // host, register port and init sequences
    // ----------------------------------------
    task automatic hostAccess(input logic dma, input logic write, input logic word,
                              input logic [7:0] off, input logic [15:0] data);
        readActive = !write;
        @(posedge sysclk);
        isDma   <= dma;
        isWrite <= write;
        isWord  <= word;
        regAddr <= off;
        dataIn  <= data;
        cmdReq  <= 1'b1;
        do @(posedge sysclk); while (!cmdAck);
        cmdReq <= 1'b0;
        do @(posedge sysclk); while (cmdAck);   // ack drops once back in idle
    endtask

    task automatic writeReg(input logic [7:0] off, input logic word, input logic [15:0] data);
        expAddr = laneAddr(off, word);
        hostAccess(1'b0, 1'b1, word, off, data);
        storeMirror(off, word, data);
    endtask

    task automatic readReg(input logic [7:0] off, input logic word);
        expAddr = laneAddr(off, word);
        expData = {byteAt({off[7:1], 1'b1}), byteAt({off[7:1], 1'b0})};
        hostAccess(1'b0, 1'b0, word, off, 16'h0000);
    endtask

    task automatic dmaAccess(input logic write, input logic [15:0] data);
        dmaActive = 1'b1;
        if (write) dmaExp.push_back(data);
        else expData = dmaExp.pop_front();
        hostAccess(1'b1, write, 1'b1, 8'h00, data);
        dmaActive = 1'b0;
    endtask

    task automatic regWrite(input logic [15:0] waddr, input regCmdWordT word);
        @(posedge sysclk);
        regWen   <= 1'b1;
        regWaddr <= waddr;
        regWdata <= word;
        @(posedge sysclk);
        regWen <= 1'b0;
    endtask

    task automatic regAccess(input logic [7:0] off, input logic word, input logic [15:0] data);
        regCmdWordT w;
        w         = '0;
        w.isWrite = 1'b1;
        w.isWord  = word;
        w.addr    = off;
        w.data    = data;
        expAddr   = laneAddr(off, word);
        regWrite(`KSZ_REG_PORT_ADDR, w);
        do @(posedge sysclk); while (busIdle);
        do @(posedge sysclk); while (!busIdle);
        storeMirror(off, word, data);
    endtask

    task automatic initHandshake();
        do @(posedge sysclk); while (!initReq);
        initAck <= 1'b1;
        do @(posedge sysclk); while (initReq);
        initAck <= 1'b0;
    endtask

    initial begin
        logic [7:0]  off;
        logic [7:0]  base;
        logic        word;
        logic [7:0]  offQ [$];
        logic        wordQ [$];
        regCmdWordT  w;
        cmdReq   = 1'b0;
        isDma    = 1'b0;
        isWrite  = 1'b0;
        isWord   = 1'b0;
        regAddr  = '0;
        dataIn   = '0;
        initAck  = 1'b0;
        regWen   = 1'b0;
        regWaddr = '0;
        regWdata = '0;
        initHandshake();

        // byte lanes 0-3 and both word halves before random offsets
        base = 8'(randomBits(5) << 3);
        for (int i = 0; i < 14; i++) begin
            if (i < 4) begin
                off  = base + 8'(i);
                word = 1'b0;
            end else if (i < 6) begin
                off  = base + 8'(2 * i - 4);
                word = 1'b1;
            end else begin
                off  = 8'(randomBits(8));
                word = 1'(randomBits(1));
                if (word) off[0] = 1'b0;           // odd word offsets unsupported
            end
            writeReg(off, word, 16'(randomBits(16)));
            offQ.push_back(off);
            wordQ.push_back(word);
        end
        foreach (offQ[i]) readReg(offQ[i], wordQ[i]);

        for (int i = 0; i < 4; i++) dmaAccess(1'b1, 16'(randomBits(16)));
        for (int i = 0; i < 4; i++) dmaAccess(1'b0, 16'h0000);

        // register port access followed by one sent while the bus is busy
        off = 8'(randomBits(8)) & 8'hfe;
        regAccess(off, 1'b1, 16'(randomBits(16)));
        readReg(off, 1'b1);
        w          = '0;
        w.isWrite  = 1'b1;
        pokeBusy   = 1'b1;
        fork
            writeReg(off ^ 8'h10, 1'b0, 16'(randomBits(16)));
            begin
                do @(posedge sysclk); while (!cmdAck);
                regWrite(`KSZ_REG_PORT_ADDR, w);
            end
        join
        do @(posedge sysclk); while (!busError);
        pokeBusy = 1'b0;
        regAccess(off ^ 8'h21, 1'b0, 16'(randomBits(16)));
        do @(posedge sysclk); while (busError);    // cleared by the accepted command
        readReg(off ^ 8'h10, 1'b0);
        readReg(off ^ 8'h21, 1'b0);

        // chip reset through the register port
        w           = '0;
        w.chipReset = 1'b1;
        regWrite(`KSZ_REG_PORT_ADDR, w);
        initHandshake();
        writeReg(base, 1'b1, 16'(randomBits(16)));
        readReg(base, 1'b1);

        repeat (4) @(posedge sysclk);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* tb.f */
+incdir+logic
logic/kszBusPkg.sv
logic/kszHostPkg.sv
logic/byteLaneAddr.sv
logic/powerUpTimer.sv
logic/regCmdDecode.sv
logic/kszBusCtrl.sv
logic/kszBusTop.sv
bench/clkGen.sv
bench/kszChipModel.sv
bench/kszBusTb.sv

/* Bender.yml */
package:
  name: ksz_bus

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/kszBusPkg.sv
      - logic/kszHostPkg.sv
      - logic/byteLaneAddr.sv
      - logic/powerUpTimer.sv
      - logic/regCmdDecode.sv
      - logic/kszBusCtrl.sv
      - logic/kszBusTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/clkGen.sv
      - bench/kszChipModel.sv
      - bench/kszBusTb.sv
